/* design/s32xPkg.sv */
package s32xPkg;

	typedef logic [4:0]  regAddr_t;	// Byte offset >> 1
	typedef logic [15:0] word_t;
	typedef logic [11:0] pulse_t;

	typedef struct packed {
		regAddr_t addr;
		word_t    wdata;
		logic     wrLo;
		logic     wrHi;
		logic     rd;
		logic     slave;	// SH side only
	} cpuBus_t;

	typedef struct packed {
		logic        fm;
		logic [12:0] unused;
		logic        res;
		logic        aden;
	} adcr_t;

	typedef struct packed {
		logic [12:0] unused;
		logic        m68s;
		logic        dma;
		logic        rv;
	} dcr_t;

	typedef struct packed {
		logic [3:0] unusedHi;
		logic [3:0] tm;
		logic       rtp;
		logic [3:0] unusedLo;
		logic       mono;
		logic       rmd;
		logic       lmd;
	} pwmcr_t;

	typedef struct packed {
		logic       hen;
		logic [2:0] unused;
		logic       v;
		logic       h;
		logic       cmd;
		logic       pwm;
	} imr_t;

	typedef struct packed {
		pwmcr_t pwmcr;
		pulse_t cycr;
		logic   mono;
	} pwmCfg_t;

	typedef struct packed {
		imr_t       master;
		imr_t       slave;
		logic [7:0] hcnt;
		logic       cmdM;
		logic       cmdS;
	} irqMasks_t;

	typedef struct packed {
		logic  m68s;
		logic  full;
		logic  empty;
		word_t dlr;
		word_t head;
	} dmaStatus_t;

	localparam regAddr_t REG_ADCR   = 5'h00;
	localparam regAddr_t REG_ICR    = 5'h01;
	localparam regAddr_t REG_HCNT   = 5'h02;
	localparam regAddr_t REG_DCR    = 5'h03;
	localparam regAddr_t REG_DLR    = 5'h08;
	localparam regAddr_t REG_FIFO   = 5'h09;
	localparam regAddr_t REG_VCLR   = 5'h0B;
	localparam regAddr_t REG_HCLR   = 5'h0C;
	localparam regAddr_t REG_CMDCLR = 5'h0D;
	localparam regAddr_t REG_PWMCLR = 5'h0E;
	localparam regAddr_t REG_COMM0  = 5'h10;
	localparam regAddr_t REG_PWMCR  = 5'h18;
	localparam regAddr_t REG_CYCR   = 5'h19;
	localparam regAddr_t REG_LPW    = 5'h1A;
	localparam regAddr_t REG_RPW    = 5'h1B;
	localparam regAddr_t REG_MPW    = 5'h1C;

	localparam word_t      ADCR_MASK  = 16'h8003;
	localparam word_t      DCR_MASK   = 16'h0003;	// dma, rv; m68s lives in the DMA unit
	localparam word_t      PWMCR_MASK = 16'h0F87;
	localparam word_t      CYCR_MASK  = 16'h0FFF;
	localparam word_t      PWR_MASK   = 16'h0FFF;
	localparam logic [7:0] IMR_MASK   = 8'h8F;

	localparam int COMM_PORTS = 8;

	// Byte-lane register update, masked bits read back as zero
	function automatic word_t mergeWr(word_t cur, cpuBus_t bus, word_t mask);
		word_t res;
		res = cur;
		if (bus.wrLo) res[7:0] = bus.wdata[7:0] & mask[7:0];
		if (bus.wrHi) res[15:8] = bus.wdata[15:8] & mask[15:8];
		return res;
	endfunction

endpackage

/* design/fifoBuffer.sv */
`timescale 1ns/1ps

module fifoBuffer #(
	parameter int  DEPTH = 4,
	parameter type T     = logic [7:0]
)
(
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         flush,
	input  logic                         push,
	input  logic                         pop,
	input  T                             din,
	output T                             dout,
	output logic [$clog2(DEPTH + 1)-1:0] count,
	output logic                         full,
	output logic                         empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T             mem [DEPTH];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	logic          doPush;
	logic          doPop;

	assign full   = count == DEPTH;
	assign empty  = count == 0;
	assign doPush = push & ~full;	// Overflow dropped
	assign doPop  = pop & ~empty;
	assign dout   = mem[rdPtr];

	always_ff @(posedge CLK) begin
		if (doPush) mem[wrPtr] <= din;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop) rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

/* design/sysRegCtrl.sv */
`timescale 1ns/1ps

module sysRegCtrl
	import s32xPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  cpuBus_t    mdBus,
	input  cpuBus_t    shBus,
	output word_t      mdRdata,
	output word_t      shRdata,

	input  dmaStatus_t dmaStat,
	output logic       dlrWr,
	output logic       dcrWr,
	output logic       dmaFlush,
	output logic       fifoPush,
	output logic       fifoPop,
	output word_t      dmaWdata,

	output pwmCfg_t    pwmCfg,
	output logic       leftPush,
	output logic       rightPush,
	output logic       cycRestart,
	output logic       timRestart,
	output pulse_t     pulseWidth,
	input  logic       leftFull,
	input  logic       leftEmpty,
	input  logic       rightFull,
	input  logic       rightEmpty,

	output irqMasks_t  irqCfg,
	output logic       vClr,
	output logic       hClr,
	output logic       pwmClr,
	output logic       clrSlave,
	output logic       shResN
);
	localparam int CI = $clog2(COMM_PORTS);

	adcr_t      adcr;
	dcr_t       dcr;
	dcr_t       mdDcr;
	imr_t       imrM;
	imr_t       imrS;
	logic [7:0] hcnt;
	logic       cmdM;
	logic       cmdS;
	pwmcr_t     pwmcr;
	pwmcr_t     pwmcrNext;
	word_t      cycr;
	word_t      cycrNext;
	word_t      comm     [COMM_PORTS];
	word_t      commNext [COMM_PORTS];
	cpuBus_t    port [2];	// 0 is the 68K, 1 the SH side
	logic       mdWr;
	logic       shWr;

	assign port[0] = mdBus;
	assign port[1] = shBus;
	assign mdWr    = mdBus.wrLo | mdBus.wrHi;
	assign shWr    = shBus.wrLo | shBus.wrHi;
	assign mdDcr   = mdBus.wdata;

	// DMA side is 68K write, SH read
	assign dlrWr    = mdWr && mdBus.addr == REG_DLR;
	assign dcrWr    = mdBus.wrLo && mdBus.addr == REG_DCR;
	assign dmaFlush = dcrWr && !mdDcr.dma;
	assign fifoPush = mdWr && mdBus.addr == REG_FIFO;
	assign fifoPop  = shBus.rd && shBus.addr == REG_FIFO;
	assign dmaWdata = mdBus.wdata;

	assign vClr     = shWr && shBus.addr == REG_VCLR;
	assign hClr     = shWr && shBus.addr == REG_HCLR;
	assign pwmClr   = shWr && shBus.addr == REG_PWMCLR;
	assign clrSlave = shBus.slave;

	assign pwmCfg = '{pwmcr: pwmcr, cycr: cycr[11:0], mono: pwmcr.mono};
	assign irqCfg = '{master: imrM, slave: imrS, hcnt: hcnt, cmdM: cmdM, cmdS: cmdS};
	assign shResN = adcr.res;

	// Registers shared by both ports, SH handled last so it wins
	always_comb begin
		regAddr_t rel;
		logic     wr;
		pwmcrNext  = pwmcr;
		cycrNext   = cycr;
		commNext   = comm;
		leftPush   = 1'b0;
		rightPush  = 1'b0;
		cycRestart = 1'b0;
		timRestart = 1'b0;
		pulseWidth = '0;
		for (int i = 0; i < 2; i++) begin
			wr  = port[i].wrLo | port[i].wrHi;
			rel = port[i].addr - REG_COMM0;
			if (wr && rel < COMM_PORTS)
				commNext[rel[CI-1:0]] = mergeWr(commNext[rel[CI-1:0]], port[i], 16'hFFFF);
			if (wr) begin
				case (port[i].addr)
					REG_PWMCR: begin
						pwmcrNext  = mergeWr(pwmcrNext, port[i], PWMCR_MASK);
						timRestart = 1'b1;
					end
					REG_CYCR: begin
						cycrNext   = mergeWr(cycrNext, port[i], CYCR_MASK);
						cycRestart = 1'b1;
					end
					REG_LPW, REG_RPW, REG_MPW: begin
						leftPush   |= port[i].addr != REG_RPW;
						rightPush  |= port[i].addr != REG_LPW;
						pulseWidth = port[i].wdata[11:0] & PWR_MASK[11:0];
					end
					default: ;
				endcase
			end
		end
	end

	function automatic word_t readWord(regAddr_t a, logic sh, logic slv);
		regAddr_t rel;
		word_t    w;
		rel = a - REG_COMM0;
		w   = '0;
		if (rel < COMM_PORTS) w = comm[rel[CI-1:0]];
		case (a)
			REG_ADCR:         w = sh ? {adcr.fm, 6'd0, adcr.aden, slv ? imrS : imrM} : adcr;
			REG_ICR:          w = {14'd0, cmdS, cmdM};
			REG_HCNT:         w = {8'd0, hcnt};
			REG_DCR:          w = {dmaStat.full, dmaStat.empty, 11'd0, dmaStat.m68s, dcr.dma, dcr.rv};
			REG_DLR:          w = dmaStat.dlr;
			REG_FIFO:         w = sh ? dmaStat.head : '0;	// 68K side is write only
			REG_PWMCR:        w = pwmcr;
			REG_CYCR:         w = cycr;
			REG_LPW:          w = {leftFull, leftEmpty, 14'd0};
			REG_RPW, REG_MPW: w = {rightFull, rightEmpty, 14'd0};
			default: ;
		endcase
		return w;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			adcr    <= '0;
			dcr     <= '0;
			imrM    <= '0;
			imrS    <= '0;
			hcnt    <= '0;
			cmdM    <= 1'b0;
			cmdS    <= 1'b0;
			pwmcr   <= '0;
			cycr    <= '0;
			comm    <= '{default: '0};
			mdRdata <= '0;
			shRdata <= '0;
		end else begin
			pwmcr <= pwmcrNext;
			cycr  <= cycrNext;
			comm  <= commNext;

			if (mdWr) begin
				case (mdBus.addr)
					REG_ADCR: adcr <= mergeWr(adcr, mdBus, ADCR_MASK);
					REG_ICR: begin	// Writing 1 raises the CMD request
						cmdM <= cmdM | (mdBus.wrLo & mdBus.wdata[0]);
						cmdS <= cmdS | (mdBus.wrLo & mdBus.wdata[1]);
					end
					REG_DCR:  dcr <= mergeWr(dcr, mdBus, DCR_MASK);
					default: ;
				endcase
			end

			if (shWr) begin
				case (shBus.addr)
					REG_ADCR: begin
						if (shBus.wrHi) adcr.fm <= shBus.wdata[15];
						if (shBus.wrLo && shBus.slave) imrS <= shBus.wdata[7:0] & IMR_MASK;
						if (shBus.wrLo && !shBus.slave) imrM <= shBus.wdata[7:0] & IMR_MASK;
					end
					REG_HCNT: if (shBus.wrLo) hcnt <= shBus.wdata[7:0];
					REG_CMDCLR: begin
						if (shBus.slave) cmdS <= 1'b0;
						else cmdM <= 1'b0;
					end
					default: ;
				endcase
			end

			if (mdBus.rd) mdRdata <= readWord(mdBus.addr, 1'b0, 1'b0);
			if (shBus.rd) shRdata <= readWord(shBus.addr, 1'b1, shBus.slave);
		end
	end

endmodule

/* design/dmaUnit.sv */
`timescale 1ns/1ps

module dmaUnit
	import s32xPkg::*;
#(
	parameter int DEPTH = 8
)
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       dlrWr,
	input  logic       dcrWr,
	input  logic       flush,
	input  logic       fifoPush,
	input  logic       fifoPop,
	input  word_t      wdata,
	output dmaStatus_t dmaStat,
	output logic       dreq0
);
	dcr_t  dcrIn;
	word_t dlr;
	word_t head;
	logic  m68s;
	logic  pushOk;
	logic  full;
	logic  empty;
	logic [$clog2(DEPTH + 1)-1:0] count;

	assign dcrIn  = wdata;
	assign pushOk = fifoPush & m68s;	// Only while the transfer is enabled

	// Empty FIFO reads as zero
	assign dmaStat = '{m68s: m68s, full: full, empty: empty, dlr: dlr,
		head: empty ? 16'h0000 : head};

	fifoBuffer #(.DEPTH(DEPTH), .T(word_t)) u_fifo (
		.CLK   (CLK),
		.RST_N (RST_N),
		.flush (flush),
		.push  (pushOk),
		.pop   (fifoPop),
		.din   (wdata),
		.dout  (head),
		.count (count),
		.full  (full),
		.empty (empty)
	);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dlr   <= '0;
			m68s  <= 1'b0;
			dreq0 <= 1'b0;
		end else begin
			if (dlrWr) dlr <= wdata;
			else if (pushOk) dlr <= dlr - 1'b1;

			if (dcrWr) m68s <= dcrIn.m68s;
			else if (pushOk && dlr == 16'd1) m68s <= 1'b0;	// Last word of the block

			dreq0 <= count >= 4;
		end
	end

endmodule

/* design/pwmUnit.sv */
`timescale 1ns/1ps

module pwmUnit
	import s32xPkg::*;
#(
	parameter int DEPTH = 3
)
(
	input  logic    CLK,
	input  logic    RST_N,
	input  logic    ce,
	input  pwmCfg_t pwmCfg,
	input  logic    leftPush,
	input  logic    rightPush,
	input  pulse_t  width,
	input  logic    cycRestart,
	input  logic    timRestart,
	output logic    leftFull,
	output logic    leftEmpty,
	output logic    rightFull,
	output logic    rightEmpty,
	output logic    pwmEvent,
	output logic    dreq1,
	output word_t   pwmL,
	output word_t   pwmR
);
	pulse_t     cycCnt;
	logic [3:0] timCnt;
	logic [3:0] tmEff;
	logic       cycEnd;	// One clock after the wrap
	logic       runTick;
	pulse_t     leftHead;
	pulse_t     rightHead;
	pulse_t     leftSrc;
	logic       leftValid;

	assign runTick = ce && (pwmCfg.pwmcr.lmd || pwmCfg.pwmcr.rmd) && pwmCfg.cycr != '0;
	assign tmEff   = (pwmCfg.pwmcr.tm == 4'd0) ? 4'd1 : pwmCfg.pwmcr.tm;

	// Mono feeds both channels from the right FIFO
	assign leftSrc   = pwmCfg.mono ? rightHead : leftHead;
	assign leftValid = pwmCfg.mono ? !rightEmpty : !leftEmpty;

	fifoBuffer #(.DEPTH(DEPTH), .T(pulse_t)) u_leftFifo (
		.CLK   (CLK),
		.RST_N (RST_N),
		.flush (1'b0),
		.push  (leftPush),
		.pop   (cycEnd),
		.din   (width),
		.dout  (leftHead),
		.count (),
		.full  (leftFull),
		.empty (leftEmpty)
	);

	fifoBuffer #(.DEPTH(DEPTH), .T(pulse_t)) u_rightFifo (
		.CLK   (CLK),
		.RST_N (RST_N),
		.flush (1'b0),
		.push  (rightPush),
		.pop   (cycEnd),
		.din   (width),
		.dout  (rightHead),
		.count (),
		.full  (rightFull),
		.empty (rightEmpty)
	);

	// Width to signed sample, coarser scaling for short cycles
	function automatic word_t toSample(pulse_t w, pulse_t cyc);
		pulse_t half;
		pulse_t t;
		half = {1'b0, cyc[11:1]};
		if (w == '0) t = '0;
		else if (w > cyc) t = half;
		else t = w - half;
		return cyc[11] ? {t, 4'b0000} : {t[11], t[9:0], 5'b00000};
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt   <= '0;
			timCnt   <= '0;
			cycEnd   <= 1'b0;
			pwmEvent <= 1'b0;
			dreq1    <= 1'b0;
		end else begin
			cycEnd   <= 1'b0;
			pwmEvent <= 1'b0;
			dreq1    <= 1'b0;

			if (cycRestart) begin
				cycCnt <= '0;
			end else if (runTick) begin
				if (cycCnt + 12'd1 == pwmCfg.cycr) begin
					cycCnt <= '0;
					cycEnd <= 1'b1;
				end else begin
					cycCnt <= cycCnt + 12'd1;
				end
			end

			if (timRestart) begin
				timCnt <= '0;
			end else if (cycEnd) begin
				if (timCnt + 4'd1 == tmEff) begin
					timCnt   <= '0;
					pwmEvent <= 1'b1;
					dreq1    <= pwmCfg.pwmcr.rtp;
				end else begin
					timCnt <= timCnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pwmL <= '0;
			pwmR <= '0;
		end else if (cycEnd) begin
			if (leftValid) pwmL <= toSample(leftSrc, pwmCfg.cycr);	// Empty FIFO holds
			if (!rightEmpty) pwmR <= toSample(rightHead, pwmCfg.cycr);
		end
	end

endmodule

/* design/irqCtrl.sv */
`timescale 1ns/1ps

module irqCtrl
	import s32xPkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       vint,
	input  logic       hint,
	input  irqMasks_t  irqCfg,
	input  logic       vClr,
	input  logic       hClr,
	input  logic       pwmClr,
	input  logic       clrSlave,
	input  logic       pwmEvent,
	output logic [2:0] mirlN,
	output logic [2:0] sirlN
);
	imr_t       mask [2];	// 0 master, 1 slave
	logic [1:0] cmdReq;
	logic [1:0] clrSel;
	logic [1:0] vLat;
	logic [1:0] hLat;
	logic [1:0] pwmLat;
	logic       vintD;
	logic       hintD;
	logic       vEdge;
	logic       hEdge;
	logic       hHit;
	logic [7:0] lineCnt;

	assign mask[0] = irqCfg.master;
	assign mask[1] = irqCfg.slave;
	assign cmdReq  = {irqCfg.cmdS, irqCfg.cmdM};
	assign clrSel  = clrSlave ? 2'b10 : 2'b01;
	assign vEdge   = vint & ~vintD;
	assign hEdge   = hint & ~hintD;
	assign hHit    = hEdge && lineCnt == irqCfg.hcnt;	// Every hcnt+1 lines

	function automatic logic [2:0] irlCode(logic v, logic h, logic cmd, logic pwm);
		if (v) return 3'b001;
		if (h) return 3'b010;
		if (cmd) return 3'b011;
		if (pwm) return 3'b100;
		return 3'b111;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vintD   <= 1'b0;
			hintD   <= 1'b0;
			lineCnt <= '0;
			vLat    <= '0;
			hLat    <= '0;
			pwmLat  <= '0;
			mirlN   <= 3'b111;
			sirlN   <= 3'b111;
		end else begin
			vintD <= vint;
			hintD <= hint;
			if (hEdge) lineCnt <= hHit ? 8'd0 : lineCnt + 8'd1;

			for (int i = 0; i < 2; i++) begin
				if (vClr && clrSel[i]) vLat[i] <= 1'b0;
				if (hClr && clrSel[i]) hLat[i] <= 1'b0;
				if (pwmClr && clrSel[i]) pwmLat[i] <= 1'b0;
				// New events override a clear in the same cycle
				if (vEdge && mask[i].v) vLat[i] <= 1'b1;
				if (hHit && mask[i].h && (mask[i].hen || !vint)) hLat[i] <= 1'b1;
				if (pwmEvent && mask[i].pwm) pwmLat[i] <= 1'b1;
			end

			mirlN <= irlCode(vLat[0], hLat[0], cmdReq[0] & mask[0].cmd, pwmLat[0]);
			sirlN <= irlCode(vLat[1], hLat[1], cmdReq[1] & mask[1].cmd, pwmLat[1]);
		end
	end

endmodule

/* design/s32xSysIf.sv */
`timescale 1ns/1ps

module s32xSysIf
	import s32xPkg::*;
#(
	parameter int DMA_DEPTH   = 8,
	parameter int PULSE_DEPTH = 3
)
(
	input  logic       CLK,
	input  logic       RST_N,
	input  cpuBus_t    mdBus,
	input  cpuBus_t    shBus,
	output word_t      mdRdata,
	output word_t      shRdata,
	input  logic       vint,
	input  logic       hint,
	input  logic       ce,
	output logic       shResN,
	output logic       dreq0,
	output logic       dreq1,
	output logic [2:0] mirlN,
	output logic [2:0] sirlN,
	output word_t      pwmL,
	output word_t      pwmR
);
	dmaStatus_t dmaStat;
	logic       dlrWr;
	logic       dcrWr;
	logic       dmaFlush;
	logic       fifoPush;
	logic       fifoPop;
	word_t      dmaWdata;
	pwmCfg_t    pwmCfg;
	logic       leftPush;
	logic       rightPush;
	logic       cycRestart;
	logic       timRestart;
	pulse_t     pulseWidth;
	logic       leftFull;
	logic       leftEmpty;
	logic       rightFull;
	logic       rightEmpty;
	logic       pwmEvent;
	irqMasks_t  irqCfg;
	logic       vClr;
	logic       hClr;
	logic       pwmClr;
	logic       clrSlave;

	sysRegCtrl u_sysRegCtrl (
		.CLK        (CLK),        .RST_N      (RST_N),
		.mdBus      (mdBus),      .shBus      (shBus),
		.mdRdata    (mdRdata),    .shRdata    (shRdata),
		.dmaStat    (dmaStat),    .dlrWr      (dlrWr),
		.dcrWr      (dcrWr),      .dmaFlush   (dmaFlush),
		.fifoPush   (fifoPush),   .fifoPop    (fifoPop),
		.dmaWdata   (dmaWdata),   .pwmCfg     (pwmCfg),
		.leftPush   (leftPush),   .rightPush  (rightPush),
		.cycRestart (cycRestart), .timRestart (timRestart),
		.pulseWidth (pulseWidth), .leftFull   (leftFull),
		.leftEmpty  (leftEmpty),  .rightFull  (rightFull),
		.rightEmpty (rightEmpty), .irqCfg     (irqCfg),
		.vClr       (vClr),       .hClr       (hClr),
		.pwmClr     (pwmClr),     .clrSlave   (clrSlave),
		.shResN     (shResN)
	);

	dmaUnit #(.DEPTH(DMA_DEPTH)) u_dmaUnit (
		.CLK      (CLK),      .RST_N   (RST_N),
		.dlrWr    (dlrWr),    .dcrWr   (dcrWr),
		.flush    (dmaFlush), .fifoPush (fifoPush),
		.fifoPop  (fifoPop),  .wdata   (dmaWdata),
		.dmaStat  (dmaStat),  .dreq0   (dreq0)
	);

	pwmUnit #(.DEPTH(PULSE_DEPTH)) u_pwmUnit (
		.CLK        (CLK),        .RST_N      (RST_N),
		.ce         (ce),         .pwmCfg     (pwmCfg),
		.leftPush   (leftPush),   .rightPush  (rightPush),
		.width      (pulseWidth), .cycRestart (cycRestart),
		.timRestart (timRestart), .leftFull   (leftFull),
		.leftEmpty  (leftEmpty),  .rightFull  (rightFull),
		.rightEmpty (rightEmpty), .pwmEvent   (pwmEvent),
		.dreq1      (dreq1),      .pwmL       (pwmL),
		.pwmR       (pwmR)
	);

	irqCtrl u_irqCtrl (
		.CLK      (CLK),      .RST_N    (RST_N),
		.vint     (vint),     .hint     (hint),
		.irqCfg   (irqCfg),   .vClr     (vClr),
		.hClr     (hClr),     .pwmClr   (pwmClr),
		.clrSlave (clrSlave), .pwmEvent (pwmEvent),
		.mirlN    (mirlN),    .sirlN    (sirlN)
	);

endmodule

/* dv/tbS32xSysIf.sv */
`timescale 1ns/1ps

module tbS32xSysIf
	import s32xPkg::*;
();
	logic       CLK;
	logic       RST_N;
	cpuBus_t    mdBus;
	cpuBus_t    shBus;
	word_t      mdRdata;
	word_t      shRdata;
	logic       vint;
	logic       hint;
	logic       ce;
	logic       shResN;
	logic       dreq0;
	logic       dreq1;
	logic [2:0] mirlN;
	logic [2:0] sirlN;
	word_t      pwmL;
	word_t      pwmR;

	logic [3:0]  opQ [$];
	logic [7:0]  offQ [$];
	word_t       dataQ [$];
	word_t       expQ [$];
	int          errors;
	int          checks;
	logic [31:0] lfsr;
	logic        loaded;

	s32xSysIf #(.DMA_DEPTH(8), .PULSE_DEPTH(3)) u_s32xSysIf (
		.CLK     (CLK),     .RST_N   (RST_N),
		.mdBus   (mdBus),   .shBus   (shBus),
		.mdRdata (mdRdata), .shRdata (shRdata),
		.vint    (vint),    .hint    (hint),
		.ce      (ce),      .shResN  (shResN),
		.dreq0   (dreq0),   .dreq1   (dreq1),
		.mirlN   (mirlN),   .sirlN   (sirlN),
		.pwmL    (pwmL),    .pwmR    (pwmR)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randWord(output word_t w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsrStep(lfsr);
			w = {w[14:0], lfsr[0]};
		end
	endtask

	function automatic word_t outputValue(logic [7:0] sel);
		case (sel)
			8'd0: return {15'd0, dreq0};
			8'd1: return {15'd0, dreq1};
			8'd2: return {13'd0, mirlN};
			8'd3: return {13'd0, sirlN};
			8'd4: return pwmL;
			8'd5: return pwmR;
			8'd6: return {15'd0, shResN};
			default: return 16'hDEAD;
		endcase
	endfunction

	function automatic string outputName(logic [7:0] sel);
		case (sel)
			8'd0: return "dreq0";
			8'd1: return "dreq1";
			8'd2: return "mirlN";
			8'd3: return "sirlN";
			8'd4: return "pwmL";
			8'd5: return "pwmR";
			8'd6: return "shResN";
			default: return "unknown output";
		endcase
	endfunction

	task automatic stepClock();
		@(posedge CLK);
		#2;	// Drive point
	endtask

	task automatic tickOnce();
		ce = 1'b1;
		stepClock();
		ce = 1'b0;
	endtask

	task automatic busWrite(input logic sh, input logic slv, input regAddr_t a, input word_t d,
			input logic lowOnly);
		cpuBus_t b;
		b = '{addr: a, wdata: d, wrLo: 1'b1, wrHi: !lowOnly, rd: 1'b0, slave: slv};
		if (sh) shBus = b;
		else mdBus = b;
		stepClock();
		mdBus = '0;
		shBus = '0;
	endtask

	task automatic busRead(input logic sh, input logic slv, input regAddr_t a, output word_t d);
		cpuBus_t b;
		b = '{addr: a, wdata: 16'h0000, wrLo: 1'b0, wrHi: 1'b0, rd: 1'b1, slave: slv};
		if (sh) shBus = b;
		else mdBus = b;
		stepClock();
		mdBus = '0;
		shBus = '0;
		d = sh ? shRdata : mdRdata;	// Valid from the cycle after the strobe
	endtask

	task automatic expectWord(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// PWM results only move on ce ticks
	task automatic tickUntil(input logic [7:0] sel, input word_t exp, input int maxTicks);
		int n;
		n = 0;
		while (outputValue(sel) !== exp && n < maxTicks) begin
			tickOnce();
			n++;
		end
		checks++;
		if (outputValue(sel) !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %h after %0d ticks, expected %h",
				$time, outputName(sel), outputValue(sel), n, exp);
		end
	endtask

	task automatic runRecord(input logic [3:0] op, input logic [7:0] off, input word_t data,
			input word_t exp);
		word_t got;
		word_t rnd;
		case (op)
			4'h0: repeat (data) stepClock();
			4'h1: busWrite(1'b0, 1'b0, off[4:0], data, 1'b0);
			4'h2: busWrite(1'b0, 1'b0, off[4:0], data, 1'b1);
			4'h3: begin
				busRead(1'b0, 1'b0, off[4:0], got);
				expectWord($sformatf("68K read of %h", off), got, exp);
			end
			4'h4: busWrite(1'b1, 1'b0, off[4:0], data, 1'b0);
			4'h5: busWrite(1'b1, 1'b1, off[4:0], data, 1'b0);
			4'h6: begin
				busRead(1'b1, 1'b0, off[4:0], got);
				expectWord($sformatf("SH master read of %h", off), got, exp);
			end
			4'h7: begin
				busRead(1'b1, 1'b1, off[4:0], got);
				expectWord($sformatf("SH slave read of %h", off), got, exp);
			end
			4'h8: repeat (data) tickOnce();
			4'h9: begin
				vint = data[0];
				stepClock();
			end
			4'hA: begin
				hint = data[0];
				stepClock();
			end
			4'hB: expectWord(outputName(off), outputValue(off), exp);
			4'hC: tickUntil(off, exp, int'(data));
			4'hD: begin	// Comm port 68K to SH
				randWord(rnd);
				busWrite(1'b0, 1'b0, off[4:0], rnd, 1'b0);
				busRead(1'b1, 1'b0, off[4:0], got);
				expectWord($sformatf("SH comm read of %h", off), got, rnd);
			end
			4'hE: begin
				randWord(rnd);
				busWrite(1'b1, 1'b0, off[4:0], rnd, 1'b0);
				busRead(1'b0, 1'b0, off[4:0], got);
				expectWord($sformatf("68K comm read of %h", off), got, rnd);
			end
			default: begin
				errors++;
				$display("Unknown operation %h in the pattern file", op);
			end
		endcase
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		mdBus  = '0;
		shBus  = '0;
		vint   = 1'b0;
		hint   = 1'b0;
		ce     = 1'b0;
		RST_N  = 1'b0;
		errors = 0;
		checks = 0;
		lfsr   = 32'ha473_7035;
		loaded = 1'b0;

		fd = $fopen("dv/s32xPatterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open dv/s32xPatterns.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h", f0, f1, f2, f3);
					if (n == 4) begin
						opQ.push_back(f0[3:0]);
						offQ.push_back(f1[7:0]);
						dataQ.push_back(f2[15:0]);
						expQ.push_back(f3[15:0]);
					end
				end
			end
			$fclose(fd);
		end
		if (opQ.size() == 0) begin
			errors++;
			$display("The pattern file holds no records");
		end
		loaded = 1'b1;

		repeat (10) @(posedge CLK);
		#2;
		RST_N = 1'b1;

		for (int i = 0; i < opQ.size(); i++)
			runRecord(opQ[i], offQ[i], dataQ[i], expQ[i]);

		stepClock();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Longest record stays well under 200 cycles
	initial begin
		wait (loaded);
		repeat (opQ.size() * 200 + 500) @(posedge CLK);
		$display("Timeout: the pattern run did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

/* dv/s32xPatterns.txt */
# Columns: op offset data expect, all hex. Offset is a register word offset or an output select
# op 0 idle cycles, 1/2 68K write word/low byte, 3 68K read, 4/5 SH write master/slave,
# 6/7 SH read master/slave, 8 ce ticks, 9 vint level, A hint level, B check output,
# C tick until output matches (data is the tick limit), D/E comm round trip 68K-SH/SH-68K
# Output select 0 dreq0, 1 dreq1, 2 mirlN, 3 sirlN, 4 pwmL, 5 pwmR, 6 shResN
B 0 0 0
B 1 0 0
B 2 0 7
B 3 0 7
B 4 0 0
B 5 0 0
B 6 0 0
1 00 0002 0
B 6 0 1
3 00 0 0002
# Comm ports
D 10 0 0
D 17 0 0
E 13 0 0
E 14 0 0
1 11 1234 0
2 11 ABCD 0
6 11 0 12CD
3 11 0 12CD
4 12 5A5A 0
3 12 0 5A5A
# DMA block of six words
1 08 0006 0
1 03 0006 0
6 03 0 4006
3 08 0 0006
1 09 1111 0
1 09 2222 0
1 09 3333 0
B 0 0 0
1 09 4444 0
B 0 0 0
0 0 1 0
B 0 0 1
1 09 5555 0
1 09 6666 0
3 03 0 0002
3 08 0 0000
1 09 7777 0
6 09 0 1111
6 09 0 2222
6 09 0 3333
B 0 0 1
6 09 0 4444
B 0 0 0
6 09 0 5555
6 09 0 6666
6 09 0 0000
6 03 0 4002
# PWM output, cycr 16
1 19 0010 0
1 1A 000C 0
1 1B 0003 0
1 18 0003 0
C 4 0014 0080
B 5 0 FF60
1 1A 0000 0
1 1B 0FFF 0
C 4 0014 0000
B 5 0 0100
# PWM FIFO flags and mono
1 19 0010 0
1 1A 0010 0
1 1A 0010 0
1 1A 0010 0
6 1A 0 8000
1 1B 0004 0
6 1B 0 0000
1 18 0007 0
C 4 0014 FF80
B 5 0 FF80
6 1A 0 0000
8 0 0022 0
6 1A 0 4000
B 4 0 FF80
# DREQ1 with rtp and tm 2
1 19 0010 0
1 18 0281 0
8 0 0011 0
B 1 0 0
C 1 0014 0001
8 0 0001 0
B 1 0 0
# Interrupts
4 00 000F 0
5 00 0005 0
6 00 0 000F
7 00 0 0005
9 0 1 0
B 2 0 7
B 3 0 7
0 0 1 0
B 2 0 1
B 3 0 7
9 0 0 0
A 0 1 0
A 0 0 0
C 1 0024 0001
B 2 0 1
B 3 0 2
4 0B 0 0
0 0 1 0
B 2 0 2
5 0C 0 0
0 0 1 0
B 3 0 4
B 2 0 2
4 0C 0 0
0 0 1 0
B 2 0 4
1 01 0001 0
0 0 1 0
B 2 0 3
4 0D 0 0
0 0 1 0
B 2 0 4
4 0E 0 0
5 0E 0 0
0 0 1 0
B 2 0 7
B 3 0 7

/* verilog.f */
design/s32xPkg.sv
design/fifoBuffer.sv
design/sysRegCtrl.sv
design/dmaUnit.sv
design/pwmUnit.sv
design/irqCtrl.sv
design/s32xSysIf.sv
dv/tbS32xSysIf.sv

/* runSim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbS32xSysIf -f verilog.f -o simv || exit 1
./obj_dir/simv | tee /dev/stderr | grep "all tests passed" > /dev/null && exit 0 || exit 1
